// File: hw/buf_pkg.sv
`default_nettype none

package buf_pkg;

    localparam int FIFO_DEPTH = 16;                   // Entries per port buffer
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int IDLE_LIMIT = 30;                   // Unread cycles before a flush

    typedef logic [PTR_W-1:0] ptr_t;                  // Wraps at FIFO_DEPTH
    typedef logic [PTR_W:0]   cnt_t;                  // 0 to FIFO_DEPTH
    typedef logic [$clog2(IDLE_LIMIT+1)-1:0] idle_t;

    // The sop bit marks a header byte
    typedef struct packed {
        logic       sop;
        logic [7:0] data;
    } entry_t;

endpackage

`default_nettype wire

// File: hw/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_if
    import buf_pkg::*;
();

    // Write side
    logic   push;          // One-cycle write strobe
    entry_t push_entry;
    cnt_t   free_cnt;      // Free entries left for pushes

    // Read side
    logic   pop;           // One-cycle read strobe when not empty
    entry_t pop_entry;     // Entry at the read pointer
    logic   empty;
    logic   flush;         // Drops the whole buffer content

    modport wr (output push, output push_entry, input free_cnt);

    modport fifo_buf (
        input  push, push_entry, pop, flush,
        output free_cnt, empty, pop_entry
    );

    modport rd (output pop, output flush, input empty, input pop_entry);

endinterface

`default_nettype wire

// File: hw/pkt_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo
    import buf_pkg::*;
(
    input wire       clk,
    input wire       rst,
    fifo_if.fifo_buf fifo
);

    entry_t mem [FIFO_DEPTH];           // Byte plus sop bit per entry
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    cnt_t   count;                      // Occupied entries

    // The producer checks free_cnt, so writes are never refused
    always_ff @(posedge clk) begin
        if (fifo.push) begin
            mem[wr_ptr] <= fifo.push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fifo.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo.push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the depth
            end
            if (fifo.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo.push, fifo.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

    assign fifo.free_cnt  = cnt_t'(FIFO_DEPTH) - count;
    assign fifo.empty     = (count == '0);
    assign fifo.pop_entry = mem[rd_ptr];     // Show-ahead read

endmodule

`default_nettype wire

// File: hw/pkt_pkg.sv
`default_nettype none

package pkt_pkg;

    localparam int NUM_PORTS = 3;    // A header naming port 3 is dropped
    localparam int LEN_MAX   = 14;   // Header, 14 bytes and parity fill one buffer

    typedef logic [1:0] port_t;      // Header bits 1:0
    typedef logic [5:0] len_t;       // Header bits 7:2

    // Receive stage FSM
    typedef enum logic [1:0] {
        IDLE,                        // Waiting for a header byte
        PAYLOAD,                     // Forwarding payload bytes
        PARITY,                      // Next byte is the parity byte
        DROP                         // Discarding a rejected packet
    } rx_state_t;

    function automatic len_t hdr_len(input logic [7:0] hdr);
        return hdr[7:2];
    endfunction

    function automatic port_t hdr_port(input logic [7:0] hdr);
        return hdr[1:0];
    endfunction

endpackage

`default_nettype wire

// File: hw/port_drain.sv
`timescale 1ns/1ps
`default_nettype none

module port_drain
    import buf_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        rd_en,
    fifo_if.rd         fifo,
    output logic       out_valid,
    output logic       out_sop,
    output logic [7:0] out_data
);

    idle_t idle_cnt;                    // Consecutive unread cycles
    logic  idle_now;
    logic  flush_q;

    // A read during the flush cycle would pop an entry that is being dropped
    assign fifo.pop   = rd_en && !fifo.empty && !flush_q;
    assign fifo.flush = flush_q;
    assign idle_now   = !fifo.empty && !rd_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            flush_q   <= 1'b0;
            idle_cnt  <= '0;
        end else begin
            out_valid <= fifo.pop;
            flush_q   <= 1'b0;
            if (flush_q || !idle_now) begin
                idle_cnt <= '0;
            end else if (idle_cnt == idle_t'(IDLE_LIMIT - 1)) begin
                idle_cnt <= '0;
                flush_q  <= 1'b1;       // Port left unread too long
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // Output byte and sop only change on a read
    always_ff @(posedge clk) begin
        if (fifo.pop) begin
            out_sop  <= fifo.pop_entry.sop;
            out_data <= fifo.pop_entry.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/router_rx.sv
`timescale 1ns/1ps
`default_nettype none

module router_rx
    import pkt_pkg::*;
    import buf_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        in_valid,
    input  wire  [7:0] in_data,
    fifo_if.wr         wr_port [NUM_PORTS],
    output logic       pkt_drop,
    output logic       parity_err
);

    rx_state_t  state;
    port_t      dst;                    // Destination latched from the header
    len_t       rem;                    // Payload bytes still to come
    logic [7:0] xor_acc;                // Running XOR of the packet so far

    len_t       len_in;
    port_t      port_in;
    cnt_t       free_cnt [NUM_PORTS];
    cnt_t       free_sel;               // Free space of the port named by in_data
    logic       hdr_ok;
    logic       push_now;
    port_t      push_port;
    entry_t     push_entry;

    assign len_in  = hdr_len(in_data);
    assign port_in = hdr_port(in_data);

    // Fan the single write path out to the port buffers
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign free_cnt[p]           = wr_port[p].free_cnt;
        assign wr_port[p].push       = push_now && (push_port == port_t'(p));
        assign wr_port[p].push_entry = push_entry;
    end

    always_comb begin
        free_sel = '0;                  // Port 3 has no buffer
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (port_in == port_t'(i)) begin
                free_sel = free_cnt[i];
            end
        end
    end

    // Accept only when header, payload and parity all fit
    assign hdr_ok = (int'(port_in) < NUM_PORTS)
                 && (len_in != '0)
                 && (int'(len_in) <= LEN_MAX)
                 && ({2'b00, free_sel} >= ({1'b0, len_in} + 7'd2));

    // Bytes go straight into the buffer on the edge that strobes them
    always_comb begin
        push_now  = 1'b0;
        push_port = dst;
        case (state)
            IDLE: begin
                push_now  = in_valid && hdr_ok;
                push_port = port_in;    // Header is not latched yet
            end
            PAYLOAD, PARITY: begin
                push_now = in_valid;
            end
            default: begin
                push_now = 1'b0;        // DROP writes nothing
            end
        endcase
    end

    assign push_entry.sop  = (state == IDLE);
    assign push_entry.data = in_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            dst        <= '0;
            rem        <= '0;
            xor_acc    <= '0;
            pkt_drop   <= 1'b0;
            parity_err <= 1'b0;
        end else begin
            pkt_drop   <= 1'b0;
            parity_err <= 1'b0;
            if (in_valid) begin
                case (state)
                    IDLE: begin
                        dst     <= port_in;
                        rem     <= len_in;
                        xor_acc <= in_data;
                        if (hdr_ok) begin
                            state <= PAYLOAD;
                        end else begin
                            state    <= DROP;
                            pkt_drop <= 1'b1;
                        end
                    end
                    PAYLOAD: begin
                        xor_acc <= xor_acc ^ in_data;
                        rem     <= rem - 1'b1;
                        if (rem == len_t'(1)) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        // Parity byte makes the XOR of the whole packet zero
                        parity_err <= ((xor_acc ^ in_data) != 8'h00);
                        state      <= IDLE;
                    end
                    DROP: begin
                        // Count out the payload, then swallow the parity byte
                        rem <= rem - 1'b1;
                        if (rem == '0) begin
                            state <= IDLE;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/router_top.sv
`timescale 1ns/1ps
`default_nettype none

module router_top
    import pkt_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire  [7:0]                in_data,
    input  wire  [NUM_PORTS-1:0]      rd_en,
    output wire  [NUM_PORTS-1:0]      out_valid,
    output wire  [NUM_PORTS-1:0]      out_sop,
    output wire  [NUM_PORTS-1:0][7:0] out_data,
    output wire                       pkt_drop,
    output wire                       parity_err
);

    // One buffer link per output port
    fifo_if port_if [NUM_PORTS] ();

    router_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .wr_port    (port_if),
        .pkt_drop   (pkt_drop),
        .parity_err (parity_err)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        pkt_fifo u_fifo (
            .clk  (clk),
            .rst  (rst),
            .fifo (port_if[p])
        );

        port_drain u_drain (
            .clk       (clk),
            .rst       (rst),
            .rd_en     (rd_en[p]),
            .fifo      (port_if[p]),
            .out_valid (out_valid[p]),
            .out_sop   (out_sop[p]),
            .out_data  (out_data[p])
        );
    end

endmodule

`default_nettype wire

// File: router.f
hw/pkt_pkg.sv
hw/buf_pkg.sv
hw/fifo_if.sv
hw/router_rx.sv
hw/pkt_fifo.sv
hw/port_drain.sv
hw/router_top.sv
test/router_sva.sv
test/tb_router.sv

// File: run_sim.sh
#!/bin/sh
# Build the router testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_router \
    --Mdir obj_dir -o tb_router_sim \
    -f router.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_router_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: test/router_sva.sv
`timescale 1ns/1ps
`default_nettype none

module router_sva
    import pkt_pkg::*;
    import buf_pkg::*;
(
    input wire                              clk,
    input wire                              rst,
    input wire [NUM_PORTS-1:0]              rd_en,
    input wire [NUM_PORTS-1:0]              out_valid,
    input wire                              pkt_drop,
    input wire                              parity_err,
    input wire [NUM_PORTS*(PTR_W+1)-1:0]    free_cnt
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // A byte only leaves a port after a read strobe on it
        a_valid_after_read: assert property (
            @(posedge clk) disable iff (rst) out_valid[p] |-> $past(rd_en[p])
        ) else $error("out_valid on port %0d without a read", p);

        a_free_range: assert property (
            @(posedge clk) disable iff (rst)
            free_cnt[p*(PTR_W+1) +: (PTR_W+1)] <= cnt_t'(FIFO_DEPTH)
        ) else $error("free_cnt above buffer depth on port %0d", p);
    end

    // Status strobes are single cycle and never back to back
    a_drop_single: assert property (
        @(posedge clk) disable iff (rst) pkt_drop |=> !pkt_drop && !parity_err
    ) else $error("pkt_drop followed by another strobe");

    a_perr_single: assert property (
        @(posedge clk) disable iff (rst) parity_err |=> !parity_err && !pkt_drop
    ) else $error("parity_err followed by another strobe");

endmodule

`default_nettype wire

// File: test/tb_router.sv
`timescale 1ns/1ps
`default_nettype none

bind router_top router_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_en),
    .out_valid  (out_valid),
    .pkt_drop   (pkt_drop),
    .parity_err (parity_err),
    .free_cnt   ({port_if[2].free_cnt, port_if[1].free_cnt, port_if[0].free_cnt})
);

module tb_router;
    import pkt_pkg::*;
    import buf_pkg::*;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       in_valid;
    logic [7:0]                 in_data;
    logic [NUM_PORTS-1:0]       rd_en;
    logic [NUM_PORTS-1:0]       read_mask;      // rd_en value applied with each drive
    wire  [NUM_PORTS-1:0]       out_valid;
    wire  [NUM_PORTS-1:0]       out_sop;
    wire  [NUM_PORTS-1:0][7:0]  out_data;
    wire                        pkt_drop;
    wire                        parity_err;
    logic [31:0]                lfsr = 32'h817f_739b;

    // Reference model state
    logic [8:0]           ref_q [NUM_PORTS][$];  // {sop, data}
    logic [NUM_PORTS-1:0] exp_valid;
    logic [8:0]           exp_entry [NUM_PORTS];
    logic                 exp_drop;
    logic                 exp_perr;
    logic [NUM_PORTS-1:0] flush_pend;
    int                   idle_cnt [NUM_PORTS];
    int                   m_state;                // 0 header, 1 accepted packet, 2 drop
    int                   m_port;
    int                   m_left;
    logic [7:0]           m_xor;

    always #4 clk = ~clk;

    router_top UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_data(in_data), .rd_en(rd_en),
        .out_valid(out_valid), .out_sop(out_sop), .out_data(out_data),
        .pkt_drop(pkt_drop), .parity_err(parity_err)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error @%0t: %s is %0h, expected %0h", $time, what, got, exp);
        $display("TEST FAILED");
        $fatal(1, "Output mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "Wait timeout");
    endtask

    // Compare the outputs with the model, then advance it by one edge
    always @(posedge clk) begin
        int   free_before [NUM_PORTS];
        int   hl;
        int   hp;
        logic nonempty;
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                ref_q[p].delete();
                idle_cnt[p] = 0;
            end
            exp_valid  = '0;
            flush_pend = '0;
            exp_drop   = 1'b0;
            exp_perr   = 1'b0;
            m_state    = 0;
        end else begin
            assert (out_valid === exp_valid)
                else report_mismatch("out_valid", 32'(out_valid), 32'(exp_valid));
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (exp_valid[p]) begin
                    assert ({out_sop[p], out_data[p]} === exp_entry[p])
                        else report_mismatch("out_sop/out_data", 32'({out_sop[p], out_data[p]}),
                                             32'(exp_entry[p]));
                end
            end
            assert (pkt_drop === exp_drop)
                else report_mismatch("pkt_drop", 32'(pkt_drop), 32'(exp_drop));
            assert (parity_err === exp_perr)
                else report_mismatch("parity_err", 32'(parity_err), 32'(exp_perr));

            for (int p = 0; p < NUM_PORTS; p++) begin
                free_before[p] = FIFO_DEPTH - ref_q[p].size();
                nonempty       = (ref_q[p].size() > 0);
                exp_valid[p]   = 1'b0;
                if (flush_pend[p]) begin
                    ref_q[p].delete();      // Reads are ignored on the flush edge
                    flush_pend[p] = 1'b0;
                    idle_cnt[p]   = 0;
                end else begin
                    if (rd_en[p] && nonempty) begin
                        exp_valid[p] = 1'b1;
                        exp_entry[p] = ref_q[p].pop_front();
                    end
                    if (nonempty && !rd_en[p]) begin
                        idle_cnt[p]++;
                        if (idle_cnt[p] == IDLE_LIMIT) begin
                            flush_pend[p] = 1'b1;
                            idle_cnt[p]   = 0;
                        end
                    end else begin
                        idle_cnt[p] = 0;
                    end
                end
            end

            exp_drop = 1'b0;
            exp_perr = 1'b0;
            if (in_valid) begin
                case (m_state)
                    0: begin
                        hl = int'(in_data[7:2]);
                        hp = int'(in_data[1:0]);
                        if (hp < NUM_PORTS && hl != 0 && hl <= LEN_MAX
                                && free_before[hp] >= hl + 2) begin
                            ref_q[hp].push_back({1'b1, in_data});
                            m_port  = hp;
                            m_left  = hl;
                            m_xor   = in_data;
                            m_state = 1;
                        end else begin
                            exp_drop = 1'b1;
                            m_left   = hl + 1;  // Payload plus parity byte
                            m_state  = 2;
                        end
                    end
                    1: begin
                        ref_q[m_port].push_back({1'b0, in_data});
                        if (m_left > 0) begin
                            m_xor = m_xor ^ in_data;
                            m_left--;
                        end else begin
                            exp_perr = ((m_xor ^ in_data) != 8'h00);
                            m_state  = 0;
                        end
                    end
                    default: begin
                        m_left--;
                        if (m_left == 0) begin
                            m_state = 0;
                        end
                    end
                endcase
            end
        end
    end

    task automatic drive(input logic valid, input logic [7:0] data);
        @(posedge clk);
        in_valid <= valid;
        in_data  <= data;
        rd_en    <= read_mask;
    endtask

    task automatic send_packet(input int port, input int len, input logic corrupt);
        logic [7:0]  acc;
        logic [31:0] r;
        acc = {6'(len), 2'(port)};
        drive(1'b1, acc);
        for (int i = 0; i < len; i++) begin
            take_bits(8, r);
            drive(1'b1, r[7:0]);
            acc = acc ^ r[7:0];
        end
        if (corrupt) begin
            acc = acc ^ 8'h10;
        end
        drive(1'b1, acc);                   // Parity byte
        drive(1'b0, 8'h00);                 // At least one idle cycle between packets
    endtask

    function automatic logic model_busy();
        logic busy;
        busy = (exp_valid != '0) || (m_state != 0) || (flush_pend != '0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            busy = busy || (ref_q[p].size() != 0);
        end
        return busy;
    endfunction

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (model_busy()) begin
            drive(1'b0, 8'h00);
            @(negedge clk);
            n++;
            if (n > limit) begin
                report_timeout("all ports to drain");
            end
        end
    endtask

    task automatic wait_port_empty(input int p, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (ref_q[p].size() != 0 || flush_pend[p]) begin
            drive(1'b0, 8'h00);
            @(negedge clk);
            n++;
            if (n > limit) begin
                report_timeout("a port flush");
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        int          port;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = 8'h00;
        rd_en     = '0;
        read_mask = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Random traffic read back promptly
        read_mask = 3'b111;
        for (int k = 0; k < 24; k++) begin
            take_bits(2, r);
            port = (r[1:0] == 2'd3) ? 0 : int'(r[1:0]);
            take_bits(4, r);
            send_packet(port, int'(r[3:0]) % LEN_MAX + 1, 1'b0);
            take_bits(2, r);
            repeat (int'(r[1:0])) drive(1'b0, 8'h00);
        end
        wait_drained(200);

        // Drops for no room, port 3 and zero length, then a clean packet
        read_mask = 3'b110;
        send_packet(0, 12, 1'b0);
        send_packet(0, 6, 1'b0);
        read_mask = 3'b111;
        send_packet(3, 4, 1'b0);
        send_packet(1, 0, 1'b0);
        send_packet(1, 3, 1'b0);
        wait_drained(200);

        // Parity error is reported but the packet still goes out
        send_packet(2, 5, 1'b1);
        send_packet(2, 5, 1'b0);
        wait_drained(200);

        // Unread port flushes itself
        read_mask = 3'b101;
        send_packet(1, 4, 1'b0);
        wait_port_empty(1, 3 * IDLE_LIMIT);
        read_mask = 3'b111;
        repeat (10) drive(1'b0, 8'h00);     // Reads on empty ports

        // Read while writing the same port
        send_packet(0, 14, 1'b0);
        send_packet(0, 7, 1'b0);
        wait_drained(200);
        repeat (5) drive(1'b0, 8'h00);

        $display("TEST OK");
        $finish;
    end

    initial begin
        #200000;
        $display("Simulation ran past its time limit");
        $display("TEST FAILED");
        $fatal(1, "Global timeout");
    end

endmodule

`default_nettype wire
